// File: verilog.f
src/rv_pkg.sv
src/instr_mem.sv
src/reg_file.sv
src/decode_unit.sv
src/hazard_unit.sv
src/forward_unit.sv
src/alu.sv
src/data_mem.sv
src/cpu.sv
tests/cpu_props.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

// File: tests/cpu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// cpu_tb
// random program run on the pipeline,
// checked against an ISA-level model
// ~~~~~~~~~~~~~~~~~~~~

module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int body_len     = 40;
  localparam int run_len      = body_len + 2;  // halt setup and ecall
  localparam int load_len     = run_len + 1;   // trailing word must never retire
  localparam int reset_cycles = 4;
  localparam int cycle_limit  = reset_cycles + 2 * run_len + 20;
  localparam logic [15:0] lfsr_seed = 16'd79;
  localparam logic [15:0] lfsr_taps = 16'hb400;

  logic                  clk, reset, prog_we, is_halted, done, timed_out;
  logic [mem_addr_w-1:0] prog_addr;
  word_t                 prog_data;
  word_t                 print_reg [0:num_regs-1];
  word_t                 expected_regs [0:num_regs-1];
  word_t                 program_words [0:imem_words-1];
  logic [15:0]           lfsr;
  int                    error_count, cycles;

  cpu dut_i (.clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
             .prog_data(prog_data), .is_halted(is_halted), .print_reg(print_reg));

  cpu_checker checker_i (.clk(clk), .reset(reset), .is_halted(is_halted),
                         .print_reg(print_reg), .expected(expected_regs), .done(done),
                         .error_count(error_count));

  always #4 clk = ~clk;                     // 8 ns period

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);  // galois form
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);               // one step per bit
    end
  endtask

  task automatic build_program();
    logic [31:0] kind, op, rd, rs1, rs2, imm, dep;
    logic [4:0]  prev_rd;
    logic [7:0]  off, last_off;
    logic [2:0]  f3;
    prev_rd  = '0;
    last_off = '0;
    for (int i = 0; i < imem_words; i++) program_words[i] = nop_word;
    for (int i = 0; i < body_len; i++) begin
      take_bits(3, kind);
      take_bits(3, op);
      take_bits(4, rd);                     // x0 now and then
      take_bits(4, rs1);
      take_bits(4, rs2);
      take_bits(1, dep);
      if (dep[0] && prev_rd != '0) rs1 = prev_rd;  // chain on the last result
      case (kind[2:0])
        3'd0, 3'd1, 3'd2: begin
          case (op[2:0])
            3'd0, 3'd1: f3 = f3_add;        // 1 is sub
            3'd2:       f3 = f3_and;
            3'd3:       f3 = f3_or;
            3'd4:       f3 = f3_xor;
            3'd5:       f3 = f3_slt;
            3'd6:       f3 = f3_sll;
            default:    f3 = f3_srl;
          endcase
          program_words[i] = {1'b0, op[2:0] == 3'd1, 5'b0, rs2[4:0], rs1[4:0], f3,
                              rd[4:0], op_rtype};
          prev_rd = rd[4:0];
        end
        3'd5: begin                         // lw, often from the last store
          take_bits(6, imm);
          off = dep[0] ? last_off : {imm[5:0], 2'b00};
          program_words[i] = {4'b0, off, 5'd0, 3'b010, rd[4:0], op_load};
          prev_rd = rd[4:0];
        end
        3'd6: begin                         // sw, data often just produced
          take_bits(6, imm);
          off = {imm[5:0], 2'b00};
          if (dep[0] && prev_rd != '0) rs2 = prev_rd;
          program_words[i] = {4'b0, off[7:5], rs2[4:0], 5'd0, 3'b010, off[4:0], op_store};
          last_off = off;
        end
        default: begin
          take_bits(12, imm);               // negative values seed slt cases
          case (op[2:0])
            3'd2:       f3 = f3_and;
            3'd3:       f3 = f3_or;
            3'd4:       f3 = f3_xor;
            3'd5, 3'd6: f3 = f3_slt;
            default:    f3 = f3_add;
          endcase
          program_words[i] = {imm[11:0], rs1[4:0], f3, rd[4:0], op_itype};
          prev_rd = rd[4:0];
        end
      endcase
    end
    program_words[body_len]     = {12'd10, 5'd0, f3_add, halt_reg, op_itype};
    program_words[body_len + 1] = ecall_word;
    program_words[body_len + 2] = {12'd1, 5'd1, f3_add, 5'd1, op_itype};  // addi x1, x1, 1
  endtask

  function automatic word_t isa_op(input logic [2:0] f3, input logic sub,
                                   input word_t a, input word_t b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return a >> b[4:0];          // logical
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // in-order model, stops at ecall with x17 == 10
  function automatic void reference_run(input int count);
    word_t x [0:num_regs-1];
    word_t mem [0:dmem_words-1];
    word_t w, a, b, addr;
    logic  halted;
    for (int i = 0; i < num_regs; i++) x[i] = '0;
    for (int i = 0; i < dmem_words; i++) mem[i] = '0;
    halted = 1'b0;
    for (int n = 0; n < count && !halted; n++) begin
      w = program_words[n];
      a = x[w[19:15]];
      b = x[w[24:20]];
      case (w[6:0])
        op_rtype: x[w[11:7]] = isa_op(w[14:12], w[30], a, b);
        op_itype: x[w[11:7]] = isa_op(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
        op_load: begin
          addr = a + {{20{w[31]}}, w[31:20]};
          x[w[11:7]] = mem[addr[7:2]];
        end
        op_store: begin
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          mem[addr[7:2]] = b;
        end
        default: halted = (w == ecall_word) && (x[17] == 32'd10);
      endcase
      x[0] = '0;                            // x0 stays zero
    end
    for (int i = 0; i < num_regs; i++) expected_regs[i] = x[i];
  endfunction

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    lfsr      = lfsr_seed;
    cycles    = 0;
    build_program();
    reference_run(load_len);
    for (int i = 0; i < load_len; i++) begin
      @(negedge clk);
      prog_we   = 1'b1;
      prog_addr = mem_addr_w'(i);
      prog_data = program_words[i];
    end
    @(negedge clk);
    prog_we = 1'b0;
    repeat (reset_cycles - 1) @(negedge clk);
    reset = 1'b0;
    while (!done && cycles < cycle_limit) begin
      @(posedge clk);                       // done settles on the falling edge
      cycles++;
    end
    timed_out = !done;
    if (timed_out) $display("Timeout: halt and register check not done in %0d cycles",
                            cycle_limit);
    $display("Checks finished: %0d errors, %0d assertion failures, %0d timeouts",
             error_count, dut_i.haz_i.props_i.fail_count, timed_out);
    if (!timed_out && error_count == 0 && dut_i.haz_i.props_i.fail_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: tests/cpu_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// cpu_checker
// waits for the halt and compares the
// register dump with the expected set
// ~~~~~~~~~~~~~~~~~~~~

module cpu_checker (
  input  logic          clk,
  input  logic          reset,
  input  logic          is_halted,
  input  rv_pkg::word_t print_reg [0:rv_pkg::num_regs-1],
  input  rv_pkg::word_t expected [0:rv_pkg::num_regs-1],
  output logic          done,
  output int            error_count
);
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int hold_cycles = 8;           // watch window after the halt

  task automatic compare_regs(input string phase);
    for (int i = 0; i < num_regs; i++) begin
      if (print_reg[i] !== expected[i]) begin
        $display("Error: print_reg[%0d] %s got 0x%08h, expected 0x%08h",
                 i, phase, print_reg[i], expected[i]);
        error_count++;
      end
    end
  endtask

  initial begin
    done        = 1'b0;
    error_count = 0;
    @(negedge reset);                       // released on a falling clock edge
    @(negedge clk);                         // one rising edge out of reset
    if (is_halted !== 1'b0) begin
      $display("is_halted was not low right after reset");
      error_count++;
    end
    while (is_halted !== 1'b1) @(negedge clk);  // timeout lives in the top
    compare_regs("at halt");
    repeat (hold_cycles) begin
      @(negedge clk);
      if (is_halted !== 1'b1) begin
        $display("is_halted dropped after the halt");
        error_count++;
      end
    end
    compare_regs("after halt");             // nothing past ecall may retire
    done = 1'b1;
  end

endmodule

// File: tests/cpu_props.sv
// ~~~~~~~~~~~~~~~~~~~~
// cpu_props
// stall and halt assertions, bound into
// every hazard_unit instance
// ~~~~~~~~~~~~~~~~~~~~

module cpu_props (
  input logic clk,
  input logic reset,
  input logic stall,
  input logic frozen,
  input logic ex_mem_read,
  input logic ex_reg_write
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;                       // read by the testbench at the end

  // load-use costs one cycle, ecall on a7 at most two
  stall_max_two: assert property (@(posedge clk) disable iff (reset)
    (stall && $past(stall)) |-> !$past(stall, 2))
    else begin
      fail_count++;
      $error("stall held for three cycles in a row");
    end

  frozen_sticky: assert property (@(posedge clk)
    $fell(frozen) |-> $past(reset))         // only reset releases the freeze
    else begin
      fail_count++;
      $error("frozen dropped without a reset");
    end

  // no writer in EX means the x17 writer sits in MEM behind a bubble,
  // it moves to WB next cycle so the wait ends there
  stall_no_ex_writer_ends: assert property (@(posedge clk) disable iff (reset)
    (stall && !ex_mem_read && !ex_reg_write) |=> !stall)
    else begin
      fail_count++;
      $error("stall with no writer in EX lasted another cycle");
    end

endmodule

bind hazard_unit cpu_props props_i (
  .clk(clk),
  .reset(reset),
  .stall(stall),
  .frozen(frozen),
  .ex_mem_read(ex_mem_read),
  .ex_reg_write(ex_reg_write)
);

// File: src/cpu.sv
// ~~~~~~~~~~~~~~~~~~~~
// cpu
// five-stage in-order RV32I subset core:
// PC, stage registers, forwarding muxes
// and writeback select
// ~~~~~~~~~~~~~~~~~~~~

module cpu (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          prog_we,
  input  logic [rv_pkg::mem_addr_w-1:0] prog_addr,
  input  rv_pkg::word_t                 prog_data,
  output logic                          is_halted,
  output rv_pkg::word_t                 print_reg [0:rv_pkg::num_regs-1]
);
  import rv_pkg::*;

  // IF
  word_t pc, if_inst;
  // ID
  word_t    if_id_inst;
  reg_idx_t id_rs1, id_rs2, id_rd;
  word_t    id_imm, id_rs1_data, id_rs2_data;
  logic     id_reg_write, id_mem_read, id_mem_write, id_mem_to_reg, id_alu_src;
  logic     id_is_ecall, id_halt, stall, frozen;
  // ID/EX
  logic     id_ex_reg_write, id_ex_mem_read, id_ex_mem_write, id_ex_mem_to_reg;
  logic     id_ex_alu_src, id_ex_halt, id_ex_funct7_b5;
  word_t    id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
  reg_idx_t id_ex_rs1, id_ex_rs2, id_ex_rd;
  logic [6:0] id_ex_op;
  logic [2:0] id_ex_funct3;
  // EX
  logic [1:0] fwd_a, fwd_b;
  word_t      ex_a, ex_rs2_val, ex_b, ex_result;
  // EX/MEM
  logic     ex_mem_reg_write, ex_mem_mem_write, ex_mem_mem_to_reg, ex_mem_halt;
  word_t    ex_mem_alu, ex_mem_store, mem_rdata;
  reg_idx_t ex_mem_rd;
  // MEM/WB
  logic     mem_wb_reg_write, mem_wb_mem_to_reg, mem_wb_halt;
  word_t    mem_wb_alu, mem_wb_rdata, wb_data;
  reg_idx_t mem_wb_rd;

  always_ff @(posedge clk) begin
    if (reset) pc <= '0;
    else if (!stall && !frozen) pc <= pc + word_t'(4);  // held for good once halted
  end

  instr_mem imem_i (.clk(clk), .we(prog_we), .waddr(prog_addr), .wdata(prog_data),
                    .pc(pc), .inst(if_inst));

  always_ff @(posedge clk) begin
    if (reset || frozen || id_halt) if_id_inst <= nop_word;  // drop younger fetches
    else if (!stall) if_id_inst <= if_inst;
  end

  decode_unit dec_i (.inst(if_id_inst), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd),
                     .imm(id_imm), .reg_write(id_reg_write), .mem_read(id_mem_read),
                     .mem_write(id_mem_write), .mem_to_reg(id_mem_to_reg),
                     .alu_src(id_alu_src), .is_ecall(id_is_ecall));

  reg_file rf_i (.clk(clk), .reset(reset), .rs1(id_rs1), .rs2(id_rs2),
                 .rd(mem_wb_rd), .rd_data(wb_data), .we(mem_wb_reg_write),
                 .rs1_data(id_rs1_data), .rs2_data(id_rs2_data), .print_reg(print_reg));

  hazard_unit haz_i (.clk(clk), .reset(reset), .id_rs1(id_rs1), .id_rs2(id_rs2),
                     .id_is_ecall(id_is_ecall), .id_rs1_data(id_rs1_data),
                     .ex_rd(id_ex_rd), .ex_mem_read(id_ex_mem_read),
                     .ex_reg_write(id_ex_reg_write), .mem_rd(ex_mem_rd),
                     .mem_reg_write(ex_mem_reg_write), .stall(stall), .frozen(frozen),
                     .id_halt(id_halt));

  // control half, a stall turns it into a bubble
  always_ff @(posedge clk) begin
    if (reset || stall) begin
      {id_ex_reg_write, id_ex_mem_read, id_ex_mem_write} <= '0;
      {id_ex_mem_to_reg, id_ex_alu_src, id_ex_halt}      <= '0;
    end else begin
      id_ex_reg_write  <= id_reg_write;
      id_ex_mem_read   <= id_mem_read;
      id_ex_mem_write  <= id_mem_write;
      id_ex_mem_to_reg <= id_mem_to_reg;
      id_ex_alu_src    <= id_alu_src;
      id_ex_halt       <= id_halt;
    end
  end

  always_ff @(posedge clk) begin            // payload half
    id_ex_rs1_data  <= id_rs1_data;
    id_ex_rs2_data  <= id_rs2_data;
    id_ex_imm       <= id_imm;
    id_ex_rs1       <= id_rs1;
    id_ex_rs2       <= id_rs2;
    id_ex_rd        <= id_rd;
    id_ex_op        <= if_id_inst[6:0];
    id_ex_funct3    <= if_id_inst[14:12];
    id_ex_funct7_b5 <= if_id_inst[30];
  end

  forward_unit fwd_i (.ex_rs1(id_ex_rs1), .ex_rs2(id_ex_rs2), .mem_rd(ex_mem_rd),
                      .mem_reg_write(ex_mem_reg_write), .wb_rd(mem_wb_rd),
                      .wb_reg_write(mem_wb_reg_write), .fwd_a(fwd_a), .fwd_b(fwd_b));

  always_comb begin
    case (fwd_a)
      fwd_mem: ex_a = ex_mem_alu;
      fwd_wb:  ex_a = wb_data;
      default: ex_a = id_ex_rs1_data;
    endcase
    case (fwd_b)
      fwd_mem: ex_rs2_val = ex_mem_alu;
      fwd_wb:  ex_rs2_val = wb_data;
      default: ex_rs2_val = id_ex_rs2_data;
    endcase
  end

  assign ex_b = id_ex_alu_src ? id_ex_imm : ex_rs2_val;

  alu alu_i (.op_code(id_ex_op), .funct3(id_ex_funct3), .funct7_b5(id_ex_funct7_b5),
             .a(ex_a), .b(ex_b), .result(ex_result));

  always_ff @(posedge clk) begin
    if (reset) begin
      {ex_mem_reg_write, ex_mem_mem_write, ex_mem_mem_to_reg, ex_mem_halt} <= '0;
    end else begin
      ex_mem_reg_write  <= id_ex_reg_write;
      ex_mem_mem_write  <= id_ex_mem_write;
      ex_mem_mem_to_reg <= id_ex_mem_to_reg;
      ex_mem_halt       <= id_ex_halt;
    end
    ex_mem_alu   <= ex_result;
    ex_mem_store <= ex_rs2_val;             // forwarded sw data
    ex_mem_rd    <= id_ex_rd;
  end

  data_mem dmem_i (.clk(clk), .reset(reset), .addr(ex_mem_alu), .wdata(ex_mem_store),
                   .we(ex_mem_mem_write), .rdata(mem_rdata));

  always_ff @(posedge clk) begin
    if (reset) begin
      {mem_wb_reg_write, mem_wb_mem_to_reg, mem_wb_halt} <= '0;
    end else begin
      mem_wb_reg_write  <= ex_mem_reg_write;
      mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
      mem_wb_halt       <= mem_wb_halt | ex_mem_halt;  // sticky once retired
    end
    mem_wb_alu   <= ex_mem_alu;
    mem_wb_rdata <= mem_rdata;
    mem_wb_rd    <= ex_mem_rd;
  end

  assign wb_data   = mem_wb_mem_to_reg ? mem_wb_rdata : mem_wb_alu;
  assign is_halted = mem_wb_halt;

endmodule

// File: src/data_mem.sv
// ~~~~~~~~~~~~~~~~~~~~
// data_mem
// 64-word data store, cleared on reset
// ~~~~~~~~~~~~~~~~~~~~

module data_mem (
  input  logic          clk,
  input  logic          reset,
  input  rv_pkg::word_t addr,
  input  rv_pkg::word_t wdata,
  input  logic          we,
  output rv_pkg::word_t rdata
);
  import rv_pkg::*;

  word_t                 mem [dmem_words];
  logic [mem_addr_w-1:0] idx;

  assign idx   = addr[mem_addr_w+1:2];      // word aligned only
  assign rdata = mem[idx];                  // async read

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < dmem_words; i++) mem[i] <= '0;
    end else if (we) begin
      mem[idx] <= wdata;
    end
  end

endmodule

// File: src/alu.sv
// ~~~~~~~~~~~~~~~~~~~~
// alu
// derives the operation from opcode and
// function bits, then computes the result
// ~~~~~~~~~~~~~~~~~~~~

module alu (
  input  logic [6:0]    op_code,
  input  logic [2:0]    funct3,
  input  logic          funct7_b5,
  input  rv_pkg::word_t a,
  input  rv_pkg::word_t b,
  output rv_pkg::word_t result
);
  import rv_pkg::*;

  alu_op_t op;

  // loads and stores fall through to add for the address
  always_comb begin
    op = alu_add;
    if (op_code == op_rtype || op_code == op_itype) begin
      case (funct3)
        f3_add: op = (op_code == op_rtype && funct7_b5) ? alu_sub : alu_add;
        f3_sll: op = alu_sll;
        f3_slt: op = alu_slt;
        f3_xor: op = alu_xor;
        f3_srl: op = alu_srl;              // sra not supported, bit 30 ignored
        f3_or:  op = alu_or;
        f3_and: op = alu_and;
        default: op = alu_add;
      endcase
    end
  end

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_slt: result = word_t'($signed(a) < $signed(b));  // signed compare
      alu_sll: result = a << b[4:0];
      alu_srl: result = a >> b[4:0];       // logical
      default: result = '0;
    endcase
  end

endmodule

// File: src/forward_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// forward_unit
// picks EX operand sources, MEM result
// ahead of WB data ahead of register value
// ~~~~~~~~~~~~~~~~~~~~

module forward_unit (
  input  rv_pkg::reg_idx_t ex_rs1,
  input  rv_pkg::reg_idx_t ex_rs2,
  input  rv_pkg::reg_idx_t mem_rd,
  input  logic             mem_reg_write,
  input  rv_pkg::reg_idx_t wb_rd,
  input  logic             wb_reg_write,
  output logic [1:0]       fwd_a,
  output logic [1:0]       fwd_b
);
  import rv_pkg::*;

  function automatic logic [1:0] pick(input reg_idx_t src);
    if (mem_reg_write && mem_rd != '0 && mem_rd == src) return fwd_mem;  // youngest first
    if (wb_reg_write && wb_rd != '0 && wb_rd == src) return fwd_wb;
    return fwd_reg;
  endfunction

  always_comb begin
    fwd_a = pick(ex_rs1);
    fwd_b = pick(ex_rs2);                   // also the store data source
  end

endmodule

// File: src/hazard_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// hazard_unit
// load-use and ecall stalls, halt detect
// and the sticky fetch freeze
// ~~~~~~~~~~~~~~~~~~~~

module hazard_unit (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t id_rs1,
  input  rv_pkg::reg_idx_t id_rs2,
  input  logic             id_is_ecall,
  input  rv_pkg::word_t    id_rs1_data,
  input  rv_pkg::reg_idx_t ex_rd,
  input  logic             ex_mem_read,
  input  logic             ex_reg_write,
  input  rv_pkg::reg_idx_t mem_rd,
  input  logic             mem_reg_write,
  output logic             stall,
  output logic             frozen,
  output logic             id_halt
);
  import rv_pkg::*;

  logic load_use;
  logic ecall_wait;

  // load result not ready until WB, one bubble needed
  assign load_use = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

  // ecall reads a7 in ID, no ID forwarding so wait for the writer
  assign ecall_wait = id_is_ecall &&
                      ((ex_reg_write && ex_rd == halt_reg) ||
                       (mem_reg_write && mem_rd == halt_reg));

  assign stall   = load_use || ecall_wait;
  assign id_halt = id_is_ecall && !stall && id_rs1_data == halt_code;

  always_ff @(posedge clk) begin
    if (reset) frozen <= 1'b0;
    else if (id_halt) frozen <= 1'b1;       // held until next reset
  end

endmodule

// File: src/decode_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// decode_unit
// splits an instruction into register fields,
// immediate and pipeline control
// ~~~~~~~~~~~~~~~~~~~~

module decode_unit (
  input  rv_pkg::word_t    inst,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::word_t    imm,
  output logic             reg_write,
  output logic             mem_read,
  output logic             mem_write,
  output logic             mem_to_reg,
  output logic             alu_src,
  output logic             is_ecall
);
  import rv_pkg::*;

  logic [6:0] opcode;
  word_t      imm_i;
  word_t      imm_s;

  assign opcode   = inst[6:0];
  assign is_ecall = (inst == ecall_word);

  // ecall reads a7 so hazard logic can test the halt code
  assign rs1 = is_ecall ? halt_reg : inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

  always_comb begin
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    mem_to_reg = 1'b0;
    alu_src    = 1'b0;
    imm        = imm_i;
    case (opcode)
      op_rtype: begin
        reg_write = 1'b1;                   // rs1 op rs2
      end
      op_itype: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;                   // rs1 op imm
      end
      op_load: begin
        reg_write  = 1'b1;
        mem_read   = 1'b1;
        mem_to_reg = 1'b1;
        alu_src    = 1'b1;                  // base + offset
      end
      op_store: begin
        mem_write = 1'b1;
        alu_src   = 1'b1;
        imm       = imm_s;                  // split offset
      end
      op_system: begin
        imm = '0;                           // ecall has no datapath effect
      end
      default: begin
        imm = '0;                           // unknown op, all enables stay low
      end
    endcase
  end

endmodule

// File: src/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~
// reg_file
// 32x32 integer registers, x0 tied to zero,
// writeback bypassed to the read ports
// ~~~~~~~~~~~~~~~~~~~~

module reg_file (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t   rd_data,
  input  logic            we,
  output rv_pkg::word_t   rs1_data,
  output rv_pkg::word_t   rs2_data,
  output rv_pkg::word_t   print_reg [0:rv_pkg::num_regs-1]
);
  import rv_pkg::*;

  word_t regs [num_regs];

  function automatic word_t read_port(input reg_idx_t idx);
    if (idx == '0) return '0;               // x0 reads zero
    if (we && idx == rd) return rd_data;    // same-cycle write wins
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) regs[i] <= '0;
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;                  // x0 never written
    end
  end

  assign print_reg = regs;                  // dump for the checker

endmodule

// File: src/instr_mem.sv
// ~~~~~~~~~~~~~~~~~~~~
// instr_mem
// 64-word program store, loaded before the
// run, read combinationally by fetch
// ~~~~~~~~~~~~~~~~~~~~

module instr_mem (
  input  logic                        clk,
  input  logic                        we,     // load strobe
  input  logic [rv_pkg::mem_addr_w-1:0] waddr,
  input  rv_pkg::word_t               wdata,
  input  rv_pkg::word_t               pc,
  output rv_pkg::word_t               inst
);
  import rv_pkg::*;

  word_t                 mem [imem_words];
  logic [mem_addr_w:0]   fill;              // words loaded so far, in order
  logic [mem_addr_w-1:0] idx;
  logic                  in_prog;

  assign idx     = pc[mem_addr_w+1:2];      // word index
  assign in_prog = (pc[xlen-1:mem_addr_w+2] == '0) && ({1'b0, idx} < fill);
  assign inst    = in_prog ? mem[idx] : nop_word;  // past the end runs nops

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
      fill       <= {1'b0, waddr} + 1'b1;
    end
  end

endmodule

// File: src/rv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// rv_pkg
// shared widths, encodings and types for the
// five-stage RV32I subset pipeline
// ~~~~~~~~~~~~~~~~~~~~

package rv_pkg;

  // widths
  localparam int xlen       = 32;          // data and address width
  localparam int reg_addr_w = 5;           // register index width
  localparam int num_regs   = 32;          // architectural registers

  // memory sizes
  localparam int imem_words = 64;          // instruction words
  localparam int dmem_words = 64;          // data words
  localparam int mem_addr_w = 6;           // word index width

  // opcodes
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 codes, shared by R and I type
  localparam logic [2:0] f3_add = 3'b000;  // also sub
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl = 3'b101;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // special words
  localparam logic [xlen-1:0] ecall_word = 32'h0000_0073;
  localparam logic [xlen-1:0] nop_word   = 32'h0000_0013;  // addi x0, x0, 0

  // halt convention, a7 == 10
  localparam logic [reg_addr_w-1:0] halt_reg  = 5'd17;
  localparam logic [xlen-1:0]       halt_code = 32'd10;

  // EX operand source select
  localparam logic [1:0] fwd_reg = 2'd0;   // value read in ID
  localparam logic [1:0] fwd_mem = 2'd1;   // EX/MEM ALU result
  localparam logic [1:0] fwd_wb  = 2'd2;   // writeback data

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl
  } alu_op_t;

endpackage
